// ==== sdram_macros.svh ====
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// DRAM clock, 100 ns period
`define SDRAM_CLK_HZ 10_000_000

// Device geometry
`define SDRAM_ROW_W  12
`define SDRAM_COL_W  8
`define SDRAM_BANK_W 2
`define SDRAM_DATA_W 16

// User address is {bank, column, row}
`define SDRAM_ADDR_W (`SDRAM_BANK_W + `SDRAM_COL_W + `SDRAM_ROW_W)

`define SDRAM_CAS_LAT 2

// Nanoseconds to clock cycles, rounded down plus one cycle of margin
`define SDRAM_NS_CYC(ns) (((`SDRAM_CLK_HZ / 1_000_000) * (ns)) / 1000 + 1)

`define SDRAM_T_WAIT ((`SDRAM_CLK_HZ / 1_000_000) * 200)       // 200 us power-up wait
`define SDRAM_T_RP   `SDRAM_NS_CYC(20)                         // Precharge period
`define SDRAM_T_RCD  `SDRAM_NS_CYC(20)                         // Activate to read/write
`define SDRAM_T_RFC  `SDRAM_NS_CYC(70)                         // Auto-refresh cycle
`define SDRAM_T_MRD  2                                         // Mode register delay
`define SDRAM_T_RDL  2                                         // Write recovery
`define SDRAM_T_REFI ((`SDRAM_CLK_HZ / 1_000_000) * 156 / 10)  // 15.6 us refresh interval

// Wait counter must reach the longest delay
`define SDRAM_CNT_W $clog2(`SDRAM_T_WAIT + 1)

`endif

// ==== sdram_dev_pkg.sv ====
`include "sdram_macros.svh"

package sdram_dev_pkg;

  typedef logic [`SDRAM_BANK_W-1:0] bank_t;
  typedef logic [`SDRAM_ROW_W-1:0]  row_t;   // Also the width of the address pins
  typedef logic [`SDRAM_COL_W-1:0]  col_t;
  typedef logic [`SDRAM_DATA_W-1:0] data_t;

  localparam int NUM_BANKS = 2 ** `SDRAM_BANK_W;

  // Pin order {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP       = 4'b0111,
    CMD_ACTIVE    = 4'b0011,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001,
    CMD_MODE      = 4'b0000
  } sdram_cmd_t;

  // A11:A10 reserved, A9 single write, A8:A7 normal, A6:A4 CAS, A3 sequential, A2:A0 BL1
  localparam row_t MODE_WORD = {2'b00, 1'b1, 2'b00, 3'(`SDRAM_CAS_LAT), 1'b0, 3'b000};

  localparam int A10_ALL_BANKS = 10;  // Precharge all banks when set

endpackage

// ==== sdram_ctrl_pkg.sv ====
package sdram_ctrl_pkg;

  typedef enum logic [4:0] {
    ST_RESET,
    ST_PWR_WAIT,    // 200 us after power-up
    ST_PALL,
    ST_PALL_TRP,
    ST_REF1,
    ST_REF1_TRFC,
    ST_REF2,
    ST_REF2_TRFC,
    ST_MRS,
    ST_MRS_TMRD,
    ST_READY,
    ST_REFRESH,
    ST_WR_ACT,
    ST_WR_TRCD,
    ST_WR_WRITE,
    ST_WR_TRDL,
    ST_WR_PRE,
    ST_RD_PRE,      // Row miss enters here
    ST_RD_TRP,
    ST_RD_ACT,
    ST_RD_TRCD,
    ST_RD_READ,     // Row hit enters here
    ST_RD_CAS,
    ST_RD_SAMPLE
  } ctrl_state_t;

endpackage

// ==== sdram_refresh.sv ====
`include "sdram_macros.svh"

module sdram_refresh (
  input  logic i_dram_clk,
  input  logic i_rst_n,
  input  logic i_refresh_en,
  input  logic i_refresh_ack,
  output logic o_refresh_req
);

  localparam int CNT_W = $clog2(`SDRAM_T_REFI);
  localparam logic [CNT_W-1:0] REFI_LAST = CNT_W'(`SDRAM_T_REFI - 1);

  logic [CNT_W-1:0] interval_cnt;
  logic             expired;

  assign expired = i_refresh_en && (interval_cnt == REFI_LAST);

  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      interval_cnt <= '0;
    end else if (expired) begin
      interval_cnt <= '0;
    end else if (i_refresh_en) begin
      interval_cnt <= interval_cnt + 1'b1;
    end
  end

  // Held until the sequencer issues REFRESH
  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      o_refresh_req <= 1'b0;
    end else begin
      o_refresh_req <= expired || (o_refresh_req && !i_refresh_ack);
    end
  end

  a_ack_needs_req: assert property (@(posedge i_dram_clk) disable iff (!i_rst_n)
    i_refresh_ack |-> o_refresh_req);

endmodule

// ==== sdram_open_rows.sv ====
module sdram_open_rows
  import sdram_dev_pkg::*;
(
  input  logic  i_dram_clk,
  input  logic  i_rst_n,
  input  logic  i_record,     // Read activation opened i_row in i_bank
  input  logic  i_close,      // Bank i_bank was precharged
  input  logic  i_close_all,  // Refresh closed every bank
  input  bank_t i_bank,
  input  row_t  i_row,
  input  bank_t i_rd_bank,
  input  row_t  i_rd_row,
  output logic  o_row_hit
);

  row_t                 open_row [NUM_BANKS];
  logic [NUM_BANKS-1:0] row_valid;

  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      row_valid <= '0;
    end else if (i_close_all) begin
      row_valid <= '0;
    end else if (i_record) begin
      row_valid[i_bank] <= 1'b1;
    end else if (i_close) begin
      row_valid[i_bank] <= 1'b0;
    end
  end

  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_BANKS; i++) begin
        open_row[i] <= '0;
      end
    end else if (i_record) begin
      open_row[i_bank] <= i_row;
    end
  end

  assign o_row_hit = row_valid[i_rd_bank] && (open_row[i_rd_bank] == i_rd_row);

  a_no_record_close: assert property (@(posedge i_dram_clk) disable iff (!i_rst_n)
    !(i_record && i_close));

endmodule

// ==== sdram_fsm.sv ====
`include "sdram_macros.svh"

module sdram_fsm
  import sdram_dev_pkg::*;
  import sdram_ctrl_pkg::*;
(
  input  logic       i_dram_clk,
  input  logic       i_rst_n,
  input  logic       i_wr_req,
  input  logic       i_rd_req,
  input  logic       i_row_hit,
  input  logic       i_refresh_req,
  input  bank_t      i_wr_bank,
  input  bank_t      i_rd_bank,
  input  row_t       i_wr_row,
  input  row_t       i_rd_row,
  input  col_t       i_wr_col,
  input  col_t       i_rd_col,
  output sdram_cmd_t o_cmd,
  output row_t       o_addr,
  output bank_t      o_ba,
  output logic [1:0] o_dqm,           // {ldqm, udqm}
  output logic       o_dq_oe,
  output logic       o_sample,
  output logic       o_idle,
  output logic       o_refresh_en,
  output logic       o_refresh_ack,
  output logic       o_row_record,
  output logic       o_row_close,
  output logic       o_row_close_all
);

  localparam int CW = `SDRAM_CNT_W;
  localparam logic [CW-1:0] WAIT_LAST = CW'(`SDRAM_T_WAIT - 1);
  localparam logic [CW-1:0] RP_LAST   = CW'(`SDRAM_T_RP - 1);
  localparam logic [CW-1:0] RCD_LAST  = CW'(`SDRAM_T_RCD - 1);
  localparam logic [CW-1:0] RFC_LAST  = CW'(`SDRAM_T_RFC - 1);
  localparam logic [CW-1:0] MRD_LAST  = CW'(`SDRAM_T_MRD - 1);
  localparam logic [CW-1:0] RDL_LAST  = CW'(`SDRAM_T_RDL - 1);
  localparam logic [CW-1:0] CAS_LAST  = CW'(`SDRAM_CAS_LAT - 2);  // Sample state takes the last cycle

  ctrl_state_t    curr_state, next_state;
  logic [CW-1:0]  wait_cnt;

  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      curr_state <= ST_RESET;
    end else begin
      curr_state <= next_state;
    end
  end

  // Restarts on every state change, so each wait state counts from zero
  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n || (next_state != curr_state)) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_comb begin
    next_state = curr_state;
    unique case (curr_state)
      ST_RESET:     next_state = ST_PWR_WAIT;
      ST_PWR_WAIT:  if (wait_cnt == WAIT_LAST) next_state = ST_PALL;
      ST_PALL:      next_state = ST_PALL_TRP;
      ST_PALL_TRP:  if (wait_cnt == RP_LAST) next_state = ST_REF1;
      ST_REF1:      next_state = ST_REF1_TRFC;
      ST_REF1_TRFC: if (wait_cnt == RFC_LAST) next_state = ST_REF2;
      ST_REF2:      next_state = ST_REF2_TRFC;
      ST_REF2_TRFC: if (wait_cnt == RFC_LAST) next_state = ST_MRS;
      ST_MRS:       next_state = ST_MRS_TMRD;
      ST_MRS_TMRD:  if (wait_cnt == MRD_LAST) next_state = ST_READY;
      ST_READY: begin
        if (i_refresh_req) begin
          next_state = ST_REFRESH;            // Refresh beats any user request
        end else if (i_wr_req) begin
          next_state = ST_WR_ACT;
        end else if (i_rd_req) begin
          next_state = i_row_hit ? ST_RD_READ : ST_RD_PRE;
        end
      end
      ST_REFRESH:   next_state = ST_READY;
      ST_WR_ACT:    next_state = ST_WR_TRCD;
      ST_WR_TRCD:   if (wait_cnt == RCD_LAST) next_state = ST_WR_WRITE;
      ST_WR_WRITE:  next_state = ST_WR_TRDL;
      ST_WR_TRDL:   if (wait_cnt == RDL_LAST) next_state = ST_WR_PRE;
      ST_WR_PRE:    next_state = ST_READY;
      ST_RD_PRE:    next_state = ST_RD_TRP;
      ST_RD_TRP:    if (wait_cnt == RP_LAST) next_state = ST_RD_ACT;
      ST_RD_ACT:    next_state = ST_RD_TRCD;
      ST_RD_TRCD:   if (wait_cnt == RCD_LAST) next_state = ST_RD_READ;
      ST_RD_READ:   next_state = ST_RD_CAS;
      ST_RD_CAS:    if (wait_cnt == CAS_LAST) next_state = ST_RD_SAMPLE;
      ST_RD_SAMPLE: next_state = ST_READY;
      default:      next_state = ST_RESET;
    endcase
  end

  // Pin outputs are registered from next_state so they line up with curr_state
  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      o_cmd           <= CMD_NOP;
      o_addr          <= '0;
      o_ba            <= '0;
      o_dqm           <= 2'b11;
      o_dq_oe         <= 1'b0;
      o_sample        <= 1'b0;
      o_idle          <= 1'b0;
      o_refresh_en    <= 1'b0;
      o_refresh_ack   <= 1'b0;
      o_row_record    <= 1'b0;
      o_row_close     <= 1'b0;
      o_row_close_all <= 1'b0;
    end else begin
      o_cmd           <= CMD_NOP;
      o_addr          <= '0;
      o_ba            <= '0;
      o_dqm           <= 2'b11;
      o_dq_oe         <= 1'b0;
      o_sample        <= 1'b0;
      o_idle          <= (next_state == ST_READY);
      o_refresh_en    <= o_refresh_en || (next_state == ST_READY);  // Stays on once ready
      o_refresh_ack   <= 1'b0;
      o_row_record    <= 1'b0;
      o_row_close     <= 1'b0;
      o_row_close_all <= 1'b0;
      case (next_state)
        ST_PALL: begin
          o_cmd  <= CMD_PRECHARGE;
          o_addr <= row_t'(1) << A10_ALL_BANKS;
        end
        ST_REF1, ST_REF2: o_cmd <= CMD_REFRESH;
        ST_MRS: begin
          o_cmd  <= CMD_MODE;
          o_addr <= MODE_WORD;
        end
        ST_REFRESH: begin
          o_cmd           <= CMD_REFRESH;
          o_refresh_ack   <= 1'b1;
          o_row_close_all <= 1'b1;           // Refresh leaves all banks idle
        end
        ST_WR_ACT: begin
          o_cmd  <= CMD_ACTIVE;
          o_addr <= i_wr_row;
          o_ba   <= i_wr_bank;
        end
        ST_WR_WRITE: begin
          o_cmd   <= CMD_WRITE;
          o_addr  <= row_t'(i_wr_col);       // A10 low, no auto-precharge
          o_ba    <= i_wr_bank;
          o_dqm   <= 2'b00;                  // Write DQM latency is zero
          o_dq_oe <= 1'b1;
        end
        ST_WR_PRE: begin
          o_cmd       <= CMD_PRECHARGE;
          o_ba        <= i_wr_bank;
          o_row_close <= 1'b1;
        end
        ST_RD_PRE: begin
          o_cmd <= CMD_PRECHARGE;
          o_ba  <= i_rd_bank;
        end
        ST_RD_ACT: begin
          o_cmd        <= CMD_ACTIVE;
          o_addr       <= i_rd_row;
          o_ba         <= i_rd_bank;
          o_row_record <= 1'b1;              // Table takes bank and row from o_ba/o_addr
        end
        ST_RD_READ: begin
          o_cmd  <= CMD_READ;
          o_addr <= row_t'(i_rd_col);
          o_ba   <= i_rd_bank;
          o_dqm  <= 2'b00;                   // Read DQM latency is two cycles
        end
        ST_RD_CAS:    o_dqm    <= 2'b00;
        ST_RD_SAMPLE: o_sample <= 1'b1;
        default: ;
      endcase
    end
  end

  a_oe_with_write: assert property (@(posedge i_dram_clk) disable iff (!i_rst_n)
    o_dq_oe |-> (o_cmd == CMD_WRITE));

  a_trcd_before_read: assert property (@(posedge i_dram_clk) disable iff (!i_rst_n)
    (o_cmd == CMD_ACTIVE) |=> (o_cmd != CMD_READ) [* `SDRAM_T_RCD]);

endmodule

// ==== sdram_ctrl.sv ====
`include "sdram_macros.svh"

module sdram_ctrl
  import sdram_dev_pkg::*;
(
  input  logic                     i_dram_clk,
  input  logic                     i_rst_n,
  input  logic                     i_wr_req,
  input  logic                     i_rd_req,
  input  logic [`SDRAM_ADDR_W-1:0] i_wr_addr,   // {bank, col, row}
  input  logic [`SDRAM_ADDR_W-1:0] i_rd_addr,   // {bank, col, row}
  input  data_t                    i_wr_data,
  input  data_t                    i_dram_dq,
  output data_t                    o_rd_data,
  output logic                     o_rd_rdy,
  output logic                     o_idle,
  output data_t                    o_dram_dq,
  output logic                     o_dram_dq_oe,
  output row_t                     o_dram_addr,
  output bank_t                    o_dram_ba,
  output logic                     o_dram_ldqm,
  output logic                     o_dram_udqm,
  output logic                     o_dram_cs_n,
  output logic                     o_dram_ras_n,
  output logic                     o_dram_cas_n,
  output logic                     o_dram_we_n,
  output logic                     o_dram_clk,
  output logic                     o_dram_cke
);

  bank_t      wr_bank, rd_bank;
  col_t       wr_col, rd_col;
  row_t       wr_row, rd_row;
  sdram_cmd_t cmd;
  logic [1:0] dqm;
  logic       sample;
  logic       refresh_en, refresh_req, refresh_ack;
  logic       row_hit, row_record, row_close, row_close_all;

  assign wr_bank = i_wr_addr[`SDRAM_ADDR_W-1 -: `SDRAM_BANK_W];
  assign rd_bank = i_rd_addr[`SDRAM_ADDR_W-1 -: `SDRAM_BANK_W];
  assign wr_col  = i_wr_addr[`SDRAM_ROW_W +: `SDRAM_COL_W];
  assign rd_col  = i_rd_addr[`SDRAM_ROW_W +: `SDRAM_COL_W];
  assign wr_row  = i_wr_addr[`SDRAM_ROW_W-1:0];
  assign rd_row  = i_rd_addr[`SDRAM_ROW_W-1:0];

  assign {o_dram_cs_n, o_dram_ras_n, o_dram_cas_n, o_dram_we_n} = cmd;
  assign {o_dram_ldqm, o_dram_udqm} = dqm;
  assign o_dram_dq  = i_wr_data;       // Only seen by the device while o_dram_dq_oe is high
  assign o_dram_clk = i_dram_clk;
  assign o_dram_cke = 1'b1;

  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      o_rd_data <= '0;
    end else if (sample) begin
      o_rd_data <= i_dram_dq;
    end
  end

  always_ff @(posedge i_dram_clk) begin
    if (!i_rst_n) begin
      o_rd_rdy <= 1'b0;
    end else begin
      o_rd_rdy <= sample;              // Same cycle as the captured data
    end
  end

  sdram_refresh sdram_refresh_i (
    .i_dram_clk   (i_dram_clk),
    .i_rst_n      (i_rst_n),
    .i_refresh_en (refresh_en),
    .i_refresh_ack(refresh_ack),
    .o_refresh_req(refresh_req)
  );

  sdram_open_rows sdram_open_rows_i (
    .i_dram_clk (i_dram_clk),
    .i_rst_n    (i_rst_n),
    .i_record   (row_record),
    .i_close    (row_close),
    .i_close_all(row_close_all),
    .i_bank     (o_dram_ba),
    .i_row      (o_dram_addr),
    .i_rd_bank  (rd_bank),
    .i_rd_row   (rd_row),
    .o_row_hit  (row_hit)
  );

  sdram_fsm sdram_fsm_i (
    .i_dram_clk     (i_dram_clk),
    .i_rst_n        (i_rst_n),
    .i_wr_req       (i_wr_req),
    .i_rd_req       (i_rd_req),
    .i_row_hit      (row_hit),
    .i_refresh_req  (refresh_req),
    .i_wr_bank      (wr_bank),
    .i_rd_bank      (rd_bank),
    .i_wr_row       (wr_row),
    .i_rd_row       (rd_row),
    .i_wr_col       (wr_col),
    .i_rd_col       (rd_col),
    .o_cmd          (cmd),
    .o_addr         (o_dram_addr),
    .o_ba           (o_dram_ba),
    .o_dqm          (dqm),
    .o_dq_oe        (o_dram_dq_oe),
    .o_sample       (sample),
    .o_idle         (o_idle),
    .o_refresh_en   (refresh_en),
    .o_refresh_ack  (refresh_ack),
    .o_row_record   (row_record),
    .o_row_close    (row_close),
    .o_row_close_all(row_close_all)
  );

endmodule

// ==== tb_sdram_model.sv ====
`include "sdram_macros.svh"

module tb_sdram_model
  import sdram_dev_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_cs_n,
  input  logic  i_ras_n,
  input  logic  i_cas_n,
  input  logic  i_we_n,
  input  row_t  i_addr,
  input  bank_t i_ba,
  input  data_t i_dq,
  input  logic  i_dq_oe,
  input  logic  i_ldqm,
  input  logic  i_udqm,
  output data_t o_dq,
  output int    o_err_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  data_t mem [logic [`SDRAM_ADDR_W-1:0]];
  logic  active [NUM_BANKS];
  row_t  act_row [NUM_BANKS];
  data_t rd_pipe [`SDRAM_CAS_LAT];

  // Unwritten locations return a value built from the whole address
  function automatic data_t fill_word(input logic [`SDRAM_ADDR_W-1:0] a);
    return data_t'(a ^ (a >> 6) ^ 22'h2a5c3);
  endfunction

  assign o_dq = rd_pipe[`SDRAM_CAS_LAT-1];

  initial begin
    o_err_cnt = 0;
    for (int i = 0; i < NUM_BANKS; i++) active[i] = 1'b0;
    for (int i = 0; i < `SDRAM_CAS_LAT; i++) rd_pipe[i] <= '0;
  end

  always @(posedge i_clk) begin
    logic [`SDRAM_ADDR_W-1:0] key;
    data_t                    rd_word;
    rd_word = '0;
    key = {i_ba, col_t'(i_addr), act_row[i_ba]};
    case (sdram_cmd_t'({i_cs_n, i_ras_n, i_cas_n, i_we_n}))
      CMD_ACTIVE: begin
        if (active[i_ba]) begin
          $display("model: ACTIVE to bank %0d which already has an open row", i_ba);
          o_err_cnt++;
        end
        active[i_ba]  = 1'b1;
        act_row[i_ba] = i_addr;
      end
      CMD_PRECHARGE: begin
        if (i_addr[A10_ALL_BANKS]) begin
          for (int i = 0; i < NUM_BANKS; i++) active[i] = 1'b0;
        end else begin
          active[i_ba] = 1'b0;
        end
      end
      CMD_REFRESH: for (int i = 0; i < NUM_BANKS; i++) active[i] = 1'b0;
      CMD_WRITE: begin
        if (!active[i_ba] || !i_dq_oe) begin
          $display("model: WRITE to bank %0d without an open row or without data", i_ba);
          o_err_cnt++;
        end else if (!i_ldqm && !i_udqm) begin
          mem[key] = i_dq;
        end
      end
      CMD_READ: begin
        if (!active[i_ba]) begin
          $display("model: READ to bank %0d with no open row", i_ba);
          o_err_cnt++;
        end
        rd_word = mem.exists(key) ? mem[key] : fill_word(key);
      end
      default: ;
    endcase
    for (int i = `SDRAM_CAS_LAT - 1; i > 0; i--) rd_pipe[i] <= rd_pipe[i-1];
    rd_pipe[0] <= rd_word;
  end

endmodule

// ==== tb_sdram_ctrl.sv ====
`include "sdram_macros.svh"

module tb_sdram_ctrl
  import sdram_dev_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_REQ    = 32;
  localparam int WAIT_LIMIT = 100;
  localparam int REFI_SLACK = 20;

  logic clk, rst_n, wr_req, rd_req;
  logic [`SDRAM_ADDR_W-1:0] wr_addr, rd_addr;
  data_t wr_data, dram_dq_in, rd_data, dram_dq;
  logic rd_rdy, idle, dq_oe, ldqm, udqm, cs_n, ras_n, cas_n, we_n, dram_clk, cke;
  row_t dram_addr;
  bank_t dram_ba;
  sdram_cmd_t cmd_pins;
  int model_errs;

  logic [15:0] stim [0:MAX_REQ*5-1];
  logic exp_valid [NUM_BANKS];
  row_t exp_row [NUM_BANKS];
  int check_errs, tests_passed, tests_failed, since_refresh, refresh_count;
  int k_pre, k_act, k_rd, k_wr, k_rdy;
  row_t act_row;
  bank_t act_ba, op_ba;
  col_t op_col;
  data_t wr_seen, rd_seen;
  logic wr_pins_ok;

  assign cmd_pins = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});

  sdram_ctrl sdram_ctrl_i (
    .i_dram_clk(clk), .i_rst_n(rst_n), .i_wr_req(wr_req), .i_rd_req(rd_req),
    .i_wr_addr(wr_addr), .i_rd_addr(rd_addr), .i_wr_data(wr_data), .i_dram_dq(dram_dq_in),
    .o_rd_data(rd_data), .o_rd_rdy(rd_rdy), .o_idle(idle), .o_dram_dq(dram_dq),
    .o_dram_dq_oe(dq_oe), .o_dram_addr(dram_addr), .o_dram_ba(dram_ba),
    .o_dram_ldqm(ldqm), .o_dram_udqm(udqm), .o_dram_cs_n(cs_n), .o_dram_ras_n(ras_n),
    .o_dram_cas_n(cas_n), .o_dram_we_n(we_n), .o_dram_clk(dram_clk), .o_dram_cke(cke)
  );

  tb_sdram_model model_i (
    .i_clk(dram_clk), .i_cs_n(cs_n), .i_ras_n(ras_n), .i_cas_n(cas_n), .i_we_n(we_n),
    .i_addr(dram_addr), .i_ba(dram_ba), .i_dq(dram_dq), .i_dq_oe(dq_oe), .i_ldqm(ldqm),
    .i_udqm(udqm), .o_dq(dram_dq_in), .o_err_cnt(model_errs)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Sees the command of the cycle that just ended
  always @(posedge clk) begin
    if (cmd_pins == CMD_REFRESH) begin
      for (int i = 0; i < NUM_BANKS; i++) exp_valid[i] = 1'b0;
      since_refresh = 0;
      refresh_count++;
    end else begin
      since_refresh++;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      check_errs++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("%s", msg);
      check_errs++;
    end
  endtask

  task automatic wait_idle(output logic ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_LIMIT; n++) begin
      if (idle) begin
        ok = 1'b1;
        return;
      end
      step();
    end
  endtask

  // Retries when a refresh wins the arbitration
  task automatic issue(input logic is_wr, input logic [`SDRAM_ADDR_W-1:0] addr,
                       input data_t data, output logic ok);
    logic idle_ok;
    ok = 1'b0;
    for (int tries = 0; tries < 8; tries++) begin
      wait_idle(idle_ok);
      if (!idle_ok) return;
      if (is_wr) begin
        wr_addr = addr;
        wr_data = data;
        wr_req  = 1'b1;
      end else begin
        rd_addr = addr;
        rd_req  = 1'b1;
      end
      step();
      wr_req = 1'b0;
      rd_req = 1'b0;
      if (cmd_pins != CMD_REFRESH) begin
        ok = 1'b1;
        return;
      end
    end
  endtask

  // Records where each command falls relative to the cycle after acceptance
  task automatic collect_op(output logic done);
    done = 1'b0;
    {k_pre, k_act, k_rd, k_wr, k_rdy} = {-32'sd1, -32'sd1, -32'sd1, -32'sd1, -32'sd1};
    for (int k = 0; k < WAIT_LIMIT; k++) begin
      case (cmd_pins)
        CMD_PRECHARGE: if (k_pre < 0) k_pre = k;
        CMD_ACTIVE: begin
          if (k_act < 0) k_act = k;
          act_row = dram_addr;
          act_ba  = dram_ba;
        end
        CMD_READ: begin
          k_rd   = k;
          op_ba  = dram_ba;
          op_col = col_t'(dram_addr);
        end
        CMD_WRITE: begin
          k_wr       = k;
          op_ba      = dram_ba;
          op_col     = col_t'(dram_addr);
          wr_seen    = dram_dq;
          wr_pins_ok = dq_oe && !ldqm && !udqm;
        end
        default: ;
      endcase
      if (rd_rdy) begin
        k_rdy   = k;
        rd_seen = rd_data;
      end
      if (idle) begin
        done = 1'b1;
        return;
      end
      step();
    end
  endtask

  task automatic run_request(input logic [15:0] op, input bank_t b, input row_t r,
                             input col_t c, input data_t d);
    logic ok, done, hit;
    issue(op == 16'h1, {b, c, r}, d, ok);
    expect_true(ok, "request was never accepted while the controller was idle");
    if (!ok) return;
    hit = exp_valid[b] && (exp_row[b] == r);
    collect_op(done);
    expect_true(done, "controller did not return to idle after the request");
    expect_eq("o_dram_ba", op_ba, b);
    expect_eq("o_dram_addr column", op_col, c);
    if (op == 16'h1) begin
      expect_eq("ACTIVE cycle", k_act, 0);
      expect_eq("ACTIVE row", act_row, r);
      expect_true(k_wr > k_act && k_pre > k_wr, "write commands out of order");
      expect_true(wr_pins_ok, "data enable or masks wrong during WRITE");
      expect_eq("o_dram_dq", wr_seen, d);
      exp_valid[b] = 1'b0;
    end else begin
      if (hit) begin
        expect_eq("READ cycle on row hit", k_rd, 0);
        expect_true(k_act < 0 && k_pre < 0, "row hit issued ACTIVE or PRECHARGE");
      end else begin
        expect_true(k_pre >= 0 && k_pre < k_act && k_act < k_rd,
                    "row miss did not issue PRECHARGE, ACTIVE, READ in order");
        expect_eq("ACTIVE row", act_row, r);
        expect_eq("ACTIVE bank", act_ba, b);
        exp_valid[b] = 1'b1;
        exp_row[b]   = r;
      end
      expect_eq("o_rd_rdy cycle", k_rdy, k_rd + `SDRAM_CAS_LAT + 1);
      expect_eq("o_rd_data", rd_seen, d);
    end
  endtask

  task automatic run_idle(input int cycles);
    int max_gap, refreshes_before;
    max_gap = 0;
    refreshes_before = refresh_count;
    repeat (cycles) begin
      step();
      if (since_refresh > max_gap) max_gap = since_refresh;
    end
    expect_true(refresh_count > refreshes_before, "no REFRESH during the idle stretch");
    expect_true(max_gap <= `SDRAM_T_REFI + REFI_SLACK, "REFRESH interval too long");
  endtask

  // Outputs while reset is still held
  task automatic check_reset_values();
    expect_eq("o_idle", idle, 1'b0);
    expect_eq("o_rd_rdy", rd_rdy, 1'b0);
    expect_eq("o_dram_dq_oe", dq_oe, 1'b0);
    expect_eq("command pins", cmd_pins, CMD_NOP);
    expect_eq("o_dram_cke", cke, 1'b1);
    expect_eq("o_dram_ldqm", ldqm, 1'b1);
    expect_eq("o_dram_udqm", udqm, 1'b1);
  endtask

  task automatic check_init();
    sdram_cmd_t cmds [$];
    row_t       addrs [$];
    for (int n = 0; n < `SDRAM_T_WAIT + 200 && !idle; n++) begin
      if (cmd_pins != CMD_NOP) begin
        cmds.push_back(cmd_pins);
        addrs.push_back(dram_addr);
      end
      step();
    end
    expect_true(idle, "timed out waiting for o_idle after reset");
    expect_eq("init command count", cmds.size(), 4);
    if (cmds.size() == 4) begin
      expect_eq("init cmd 0", cmds[0], CMD_PRECHARGE);
      expect_eq("precharge A10", addrs[0][A10_ALL_BANKS], 1'b1);
      expect_eq("init cmd 1", cmds[1], CMD_REFRESH);
      expect_eq("init cmd 2", cmds[2], CMD_REFRESH);
      expect_eq("init cmd 3", cmds[3], CMD_MODE);
      expect_eq("mode word", addrs[3], MODE_WORD);
    end
    since_refresh = 0;
  endtask

  task automatic close_test(input int num, input string name, input int errs_before,
                            input int model_before);
    expect_eq("model error count", model_errs, model_before);
    if (check_errs == errs_before) begin
      $display("test %0d %s: pass", num, name);
      tests_passed++;
    end else begin
      $display("test %0d %s: fail", num, name);
      tests_failed++;
    end
  endtask

  initial begin
    logic [15:0] op;
    int errs_before, model_before;
    void'($urandom(32'h7b45));
    {rst_n, wr_req, rd_req, wr_addr, rd_addr, wr_data} = '0;
    {check_errs, tests_passed, tests_failed, since_refresh, refresh_count} = '0;
    for (int i = 0; i < NUM_BANKS; i++) exp_valid[i] = 1'b0;
    for (int i = 0; i < MAX_REQ * 5; i++) stim[i] = '0;
    $readmemh("sdram_stimulus.txt", stim);
    repeat (4) @(posedge clk);
    #1;
    errs_before = check_errs;
    check_reset_values();
    rst_n = 1'b1;
    check_init();
    close_test(0, "init", errs_before, 0);
    for (int i = 0; i < MAX_REQ; i++) begin
      op = stim[5*i];
      if (op == 16'h0) break;
      errs_before  = check_errs;
      model_before = model_errs;
      repeat ($urandom % 4) step();
      if (op == 16'h3) begin
        run_idle(int'(stim[5*i+4]));
      end else begin
        run_request(op, bank_t'(stim[5*i+1]), row_t'(stim[5*i+2]),
                    col_t'(stim[5*i+3]), stim[5*i+4]);
      end
      close_test(i + 1, (op == 16'h1) ? "write" : (op == 16'h2) ? "read" : "idle",
                 errs_before, model_before);
    end
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
sdram_dev_pkg.sv
sdram_ctrl_pkg.sv
sdram_refresh.sv
sdram_open_rows.sv
sdram_fsm.sv
sdram_ctrl.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_sdram_ctrl -o sim_tb

# The simulator exits non-zero on an RTL assertion, which stops the script here
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sdram_stimulus.txt ====
// op bank row col data, all hex; op 1 write, 2 read and expect data, 3 idle for data cycles
// The list ends at the first op of zero
1 0 010 05 1234
2 0 010 05 1234
2 0 010 05 1234
1 1 020 10 abcd
1 2 7ff 20 5a5a
2 1 020 10 abcd
2 2 7ff 20 5a5a
2 1 020 10 abcd
3 0 000 00 0190
1 0 011 00 c3c3
2 0 010 05 1234
2 0 011 00 c3c3
2 0 011 00 c3c3
2 1 020 10 abcd
1 3 fff ff 0f0f
2 3 fff ff 0f0f
0 0 000 00 0000
